// ==== vlog.f ====
hdl/icache_pkg.sv
hdl/icache_ram.sv
hdl/icache_way.sv
hdl/icache_ctrl.sv
hdl/icache_top.sv
tests/tb_clock.sv
tests/axi_mem_model.sv
tests/tb_icache.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_icache
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Testbench passed" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/tb_icache.sv ====
`timescale 1ns/1ps

module tb_icache;
    import icache_pkg::*;

    localparam int          STREAM_LIMIT = 3000;
    localparam logic [31:0] DATA_KEY     = 32'hc0de_0000;

    logic        clk;
    logic        rst;
    fetch_req_t  fetch;
    logic        stall;
    fetch_resp_t resp;
    axi_ar_t     ar;
    logic        arready;
    axi_r_t      r;
    logic        rready;
    logic        stall_en;
    int          ar_count;
    axi_ar_t     last_ar;
    logic        mem_fault;

    // reference view of the two ways per set
    tag_t        ref_tag [2][1 << LEN_INDEX];
    logic        ref_valid [2][1 << LEN_INDEX];
    logic        ref_lru [1 << LEN_INDEX];

    logic [31:0] req_addr [$];
    logic        req_nc [$];
    int          errors;
    int          tests_run;
    int          tests_failed;
    logic        timed_out;

    tb_clock clock_inst (
        .o_clk (clk)
    );

    icache_top icache_top_inst (
        .clk       (clk),
        .rst       (rst),
        .i_fetch   (fetch),
        .o_stall   (stall),
        .o_resp    (resp),
        .o_ar      (ar),
        .i_arready (arready),
        .i_r       (r),
        .o_rready  (rready)
    );

    axi_mem_model mem_inst (
        .clk        (clk),
        .rst        (rst),
        .i_ar       (ar),
        .o_arready  (arready),
        .o_r        (r),
        .i_rready   (rready),
        .i_stall_en (stall_en),
        .o_ar_count (ar_count),
        .o_last_ar  (last_ar),
        .o_fault    (mem_fault)
    );

    function automatic logic [31:0] make_addr(input tag_t tag, input logic [6:0] index,
                                              input logic [5:0] offset);
        return {tag, index, offset};
    endfunction

    // expected {inst1, inst2} with only the addressed word for an uncached read
    function automatic logic [63:0] expected_pair(input logic [31:0] a, input logic nc);
        logic [31:0] base;
        logic [31:0] w;
        base = {a[31:3], 3'b000};
        w    = {a[31:2], 2'b00} ^ DATA_KEY;
        if (nc) begin
            return a[2] ? {32'h0, w} : {w, 32'h0};
        end
        return {a[2] ? 32'h0 : (base ^ DATA_KEY), (base + 32'd4) ^ DATA_KEY};
    endfunction

    // hit test plus LRU update and allocation in the reference sets
    function automatic logic model_access(input logic [31:0] a, input logic nc);
        logic [LEN_INDEX-1:0] idx;
        tag_t                 tag;
        logic                 hit0;
        logic                 hit1;
        logic                 way;
        idx  = a[LEN_LINE +: LEN_INDEX];
        tag  = a[31 -: LEN_TAG];
        hit0 = ref_valid[0][idx] && (ref_tag[0][idx] == tag);
        hit1 = ref_valid[1][idx] && (ref_tag[1][idx] == tag);
        if (nc) begin
            return 1'b0;
        end
        if (hit0 || hit1) begin
            ref_lru[idx] = hit0;
            return 1'b1;
        end
        way                 = ref_lru[idx];
        ref_valid[way][idx] = 1'b1;
        ref_tag[way][idx]   = tag;
        ref_lru[idx]        = ~way;
        return 1'b0;
    endfunction

    task automatic report_mismatch(input string sig, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, sig, got, exp);
        errors++;
    endtask

    task automatic push_req(input logic [31:0] a, input logic nc);
        req_addr.push_back(a);
        req_nc.push_back(nc);
    endtask

    // issues the queued fetches as fast as the cache takes them
    task automatic run_stream(input string name);
        logic [63:0] exp_pair [$];
        logic        exp_hit [$];
        int          acc_cycle [$];
        int          issued;
        int          answered;
        int          total;
        int          cyc;
        int          ar_expected;
        logic        hit;
        total       = req_addr.size();
        issued      = 0;
        answered    = 0;
        cyc         = 0;
        ar_expected = ar_count;
        while (answered < total && !timed_out) begin
            fetch.valid    = (issued < total);
            fetch.addr     = (issued < total) ? req_addr[issued] : 32'h0;
            fetch.no_cache = (issued < total) ? req_nc[issued] : 1'b0;
            @(negedge clk);
            if (exp_hit.size() > 0 && !exp_hit[0] && cyc == acc_cycle[0] + 1 && !stall) begin
                report_mismatch("o_stall", 64'(stall), 64'(1));
            end
            if (resp.valid) begin
                if (exp_pair.size() == 0) begin
                    $display("%0t ns: %s saw a response with no fetch outstanding", $time, name);
                    errors++;
                end else begin
                    if ({resp.inst1, resp.inst2} !== exp_pair[0]) begin
                        report_mismatch("o_resp.inst1/inst2", {resp.inst1, resp.inst2},
                                        exp_pair[0]);
                    end
                    if (exp_hit[0] && cyc - acc_cycle[0] != 1) begin
                        report_mismatch("hit latency", 64'(cyc - acc_cycle[0]), 64'(1));
                    end
                    if (stall) begin
                        report_mismatch("o_stall", 64'(stall), 64'(0));
                    end
                    void'(exp_pair.pop_front());
                    void'(exp_hit.pop_front());
                    void'(acc_cycle.pop_front());
                    answered++;
                end
            end
            if (fetch.valid && !stall) begin
                hit = model_access(fetch.addr, fetch.no_cache);
                exp_pair.push_back(expected_pair(fetch.addr, fetch.no_cache));
                exp_hit.push_back(hit);
                acc_cycle.push_back(cyc);
                if (!hit) begin
                    ar_expected++;
                end
                issued++;
            end
            @(posedge clk);
            #10;
            cyc++;
            if (cyc > STREAM_LIMIT) begin
                $display("%0t ns: timeout in %s, %0d of %0d fetches answered",
                         $time, name, answered, total);
                timed_out = 1'b1;
            end
        end
        fetch = '0;
        req_addr.delete();
        req_nc.delete();
        if (ar_count != ar_expected) begin
            report_mismatch("ar_count", 64'(ar_count), 64'(ar_expected));
        end
    endtask

    task automatic close_test(input string name, input int errs_at_start);
        tests_run++;
        if (errors == errs_at_start && !timed_out) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errs_at_start);
        end
    endtask

    task automatic test_reset_state();
        int errs;
        errs = errors;
        @(negedge clk);
        if (stall !== 1'b0) begin
            report_mismatch("o_stall", 64'(stall), 64'(0));
        end
        if (resp.valid !== 1'b0) begin
            report_mismatch("o_resp.valid", 64'(resp.valid), 64'(0));
        end
        if (ar.valid !== 1'b0) begin
            report_mismatch("o_ar.valid", 64'(ar.valid), 64'(0));
        end
        if (rready !== 1'b0) begin
            report_mismatch("o_rready", 64'(rready), 64'(0));
        end
        @(posedge clk);
        #10;
        close_test("reset state", errs);
    endtask

    task automatic test_cold_miss();
        int errs;
        int ars;
        errs = errors;
        ars  = ar_count;
        push_req(32'h0001_2348, 1'b0);
        run_stream("cold miss");
        if (ar_count != ars + 1) begin
            report_mismatch("ar_count", 64'(ar_count), 64'(ars + 1));
        end
        if (last_ar.addr != 32'h0001_2340) begin
            report_mismatch("o_ar.addr", 64'(last_ar.addr), 64'h0001_2340);
        end
        if (last_ar.len != 8'd15 || last_ar.size != 3'd2) begin
            report_mismatch("o_ar.len/size", 64'({last_ar.len, last_ar.size}), 64'({8'd15, 3'd2}));
        end
        close_test("cold miss", errs);
    endtask

    task automatic test_hits();
        int errs;
        int ars;
        errs = errors;
        ars  = ar_count;
        push_req(32'h0001_2340, 1'b0);
        push_req(32'h0001_2344, 1'b0);
        push_req(32'h0001_237c, 1'b0);
        push_req(32'h0001_2350, 1'b0);
        push_req(32'h0001_2348, 1'b0);
        push_req(32'h0001_2340, 1'b0);
        run_stream("hits");
        if (ar_count != ars) begin
            report_mismatch("ar_count", 64'(ar_count), 64'(ars));
        end
        close_test("hits", errs);
    endtask

    task automatic test_bit2();
        int errs;
        errs = errors;
        // a miss and then a hit on the same address
        push_req(32'h0004_5a64, 1'b0);
        push_req(32'h0004_5a64, 1'b0);
        run_stream("bit 2");
        close_test("bit 2", errs);
    endtask

    task automatic test_lru();
        int          errs;
        int          ars;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        errs = errors;
        a    = make_addr(19'h000a1, 7'h21, 6'h08);
        b    = make_addr(19'h000b2, 7'h21, 6'h10);
        c    = make_addr(19'h000c3, 7'h21, 6'h24);
        push_req(a, 1'b0);
        push_req(b, 1'b0);
        push_req(a, 1'b0);
        push_req(c, 1'b0);
        run_stream("lru fill");
        ars = ar_count;
        push_req(a, 1'b0);
        run_stream("lru keep");
        if (ar_count != ars) begin
            report_mismatch("ar_count", 64'(ar_count), 64'(ars));
        end
        push_req(b, 1'b0);
        run_stream("lru evicted");
        if (ar_count != ars + 1) begin
            report_mismatch("ar_count", 64'(ar_count), 64'(ars + 1));
        end
        close_test("lru", errs);
    endtask

    task automatic test_uncached();
        int errs;
        int ars;
        errs = errors;
        ars  = ar_count;
        push_req(32'h0007_0100, 1'b1);
        push_req(32'h0007_0106, 1'b1);
        run_stream("uncached");
        if (last_ar.addr != 32'h0007_0104) begin
            report_mismatch("o_ar.addr", 64'(last_ar.addr), 64'h0007_0104);
        end
        if (last_ar.len != 8'd0 || last_ar.size != 3'd2) begin
            report_mismatch("o_ar.len/size", 64'({last_ar.len, last_ar.size}), 64'({8'd0, 3'd2}));
        end
        push_req(32'h0007_0108, 1'b0);
        run_stream("after uncached");
        if (ar_count != ars + 3) begin
            report_mismatch("ar_count", 64'(ar_count), 64'(ars + 3));
        end
        close_test("uncached", errs);
    endtask

    task automatic test_backpressure();
        int errs;
        int i;
        errs     = errors;
        stall_en = 1'b1;
        // three tags across two sets so that lines get evicted and hit again
        for (i = 0; i < 16; i++) begin
            push_req(make_addr(19'(8 + i % 3), 7'(40 + i % 2), 6'(i * 12)), 1'(i == 5));
        end
        run_stream("back-pressure");
        stall_en = 1'b0;
        close_test("back-pressure", errs);
    endtask

    initial begin
        rst          = 1'b1;
        fetch        = '0;
        stall_en     = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        for (int s = 0; s < (1 << LEN_INDEX); s++) begin
            ref_valid[0][s] = 1'b0;
            ref_valid[1][s] = 1'b0;
            ref_tag[0][s]   = '0;
            ref_tag[1][s]   = '0;
            ref_lru[s]      = 1'b0;
        end
        repeat (8) @(posedge clk);
        #10;
        rst = 1'b0;
        test_reset_state();
        test_cold_miss();
        test_hits();
        test_bit2();
        test_lru();
        test_uncached();
        test_backpressure();
        if (mem_fault) begin
            $display("memory model offered a read beat that was never accepted");
            errors++;
        end
        $display("tests run: %0d, tests failed: %0d, check errors: %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0 && !timed_out) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== tests/axi_mem_model.sv ====
`timescale 1ns/1ps

module axi_mem_model (
    input  logic                clk,
    input  logic                rst,
    input  icache_pkg::axi_ar_t i_ar,
    output logic                o_arready,
    output icache_pkg::axi_r_t  o_r,
    input  logic                i_rready,
    input  logic                i_stall_en,
    output int                  o_ar_count,
    output icache_pkg::axi_ar_t o_last_ar,
    output logic                o_fault
);
    import icache_pkg::*;

    localparam int RREADY_LIMIT = 64;

    logic [31:0] lfsr;

    // galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic int lfsr_bits(input int nbits);
        int v;
        int i;
        v = 0;
        for (i = 0; i < nbits; i++) begin
            v = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #10;
        end
    endtask

    task automatic serve_burst();
        int   k;
        int   guard;
        logic rdy;
        o_last_ar = i_ar;
        idle_cycles(i_stall_en ? lfsr_bits(2) : 0);
        o_arready = 1'b1;
        @(posedge clk);
        #10;
        o_arready  = 1'b0;
        o_ar_count = o_ar_count + 1;
        for (k = 0; k <= int'(o_last_ar.len); k++) begin
            o_r.valid = 1'b0;
            idle_cycles(i_stall_en ? lfsr_bits(2) : 0);
            o_r.valid = 1'b1;
            o_r.data  = (o_last_ar.addr + 32'(4 * k)) ^ 32'hc0de_0000;
            o_r.last  = (k == int'(o_last_ar.len));
            guard = 0;
            rdy   = 1'b0;
            while (!rdy && guard < RREADY_LIMIT) begin
                rdy = i_rready;
                @(posedge clk);
                #10;
                guard++;
            end
            if (!rdy) begin
                o_fault = 1'b1;
                break;
            end
        end
        o_r = '0;
    endtask

    initial begin
        lfsr       = 32'h3ba6_e892;
        o_arready  = 1'b0;
        o_r        = '0;
        o_ar_count = 0;
        o_last_ar  = '0;
        o_fault    = 1'b0;
        forever begin
            @(posedge clk);
            #10;
            if (!rst && i_ar.valid) begin
                serve_burst();
            end
        end
    end

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int HALF_PERIOD = 50
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #(HALF_PERIOD) o_clk = ~o_clk;
        end
    end

endmodule

// ==== hdl/icache_top.sv ====
`timescale 1ns/1ps

module icache_top (
    input  logic                    clk,
    input  logic                    rst,
    input  icache_pkg::fetch_req_t  i_fetch,
    output logic                    o_stall,
    output icache_pkg::fetch_resp_t o_resp,
    output icache_pkg::axi_ar_t     o_ar,
    input  logic                    i_arready,
    input  icache_pkg::axi_r_t      i_r,
    output logic                    o_rready
);
    import icache_pkg::*;

    logic        lookup_en;
    refill_wr_t  wr;
    logic        wr_way;
    tag_t        wr_tag;
    way_result_t way0_res;
    way_result_t way1_res;

    icache_way way0_inst (
        .clk         (clk),
        .rst         (rst),
        .i_lookup_en (lookup_en),
        .i_index     (i_fetch.addr[LEN_LINE +: LEN_INDEX]),
        .i_slot      (i_fetch.addr[3 +: SLOT_W]),
        .i_tag       (i_fetch.addr[31 -: LEN_TAG]),
        .i_wr        (wr),
        .i_wr_sel    (!wr_way),
        .i_wr_tag    (wr_tag),
        .o_result    (way0_res)
    );

    icache_way way1_inst (
        .clk         (clk),
        .rst         (rst),
        .i_lookup_en (lookup_en),
        .i_index     (i_fetch.addr[LEN_LINE +: LEN_INDEX]),
        .i_slot      (i_fetch.addr[3 +: SLOT_W]),
        .i_tag       (i_fetch.addr[31 -: LEN_TAG]),
        .i_wr        (wr),
        .i_wr_sel    (wr_way),
        .i_wr_tag    (wr_tag),
        .o_result    (way1_res)
    );

    icache_ctrl ctrl_inst (
        .clk         (clk),
        .rst         (rst),
        .i_fetch     (i_fetch),
        .o_stall     (o_stall),
        .o_resp      (o_resp),
        .i_way0      (way0_res),
        .i_way1      (way1_res),
        .o_lookup_en (lookup_en),
        .o_wr        (wr),
        .o_wr_way    (wr_way),
        .o_wr_tag    (wr_tag),
        .o_ar        (o_ar),
        .i_arready   (i_arready),
        .i_r         (i_r),
        .o_rready    (o_rready)
    );

endmodule

// ==== hdl/icache_ctrl.sv ====
`timescale 1ns/1ps

module icache_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  icache_pkg::fetch_req_t  i_fetch,
    output logic                    o_stall,
    output icache_pkg::fetch_resp_t o_resp,
    input  icache_pkg::way_result_t i_way0,
    input  icache_pkg::way_result_t i_way1,
    output logic                    o_lookup_en,
    output icache_pkg::refill_wr_t  o_wr,
    output logic                    o_wr_way,
    output icache_pkg::tag_t        o_wr_tag,
    output icache_pkg::axi_ar_t     o_ar,
    input  logic                    i_arready,
    input  icache_pkg::axi_r_t      i_r,
    output logic                    o_rready
);
    import icache_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        REFILL,
        UNCACHED
    } state_t;

    state_t                      state_q;
    fetch_req_t                  lkp_q;
    logic                        done_q;
    logic                        victim_q;
    logic [$clog2(NR_WORDS)-1:0] beat_q;
    logic [31:0]                 cap_lo_q;
    logic [31:0]                 cap_hi_q;
    logic [(1 << LEN_INDEX)-1:0] lru_q;
    axi_ar_t                     ar_q;
    logic                        rready_q;

    logic [LEN_INDEX-1:0] lkp_index;
    logic [SLOT_W-1:0]    lkp_slot;
    logic                 lookup_live;
    logic                 any_hit;
    logic                 miss;
    logic                 beat;
    logic [63:0]          pair;

    assign lkp_index = lkp_q.addr[LEN_LINE +: LEN_INDEX];
    assign lkp_slot  = lkp_q.addr[3 +: SLOT_W];

    // request in lookup that has not been answered yet
    assign lookup_live = lkp_q.valid && (state_q == IDLE) && !done_q;
    assign any_hit     = i_way0.hit || i_way1.hit;
    assign miss        = lookup_live && (lkp_q.no_cache || !any_hit);
    assign beat        = i_r.valid && rready_q;

    assign o_stall     = miss || (state_q != IDLE);
    assign o_lookup_en = i_fetch.valid && !o_stall;

    // refill reply comes from the captured beats
    assign pair = done_q ? {cap_hi_q, cap_lo_q} : (i_way1.hit ? i_way1.pair : i_way0.pair);

    assign o_resp.valid = done_q || (lookup_live && !miss);
    assign o_resp.inst1 = lkp_q.addr[2] ? 32'h0 : pair[31:0];
    assign o_resp.inst2 = pair[63:32];

    // beat n of the line lands in half n%2 of slot n/2
    assign o_wr.data_we = beat && (state_q == REFILL);
    assign o_wr.half    = beat_q[0];
    assign o_wr.tag_we  = beat && (state_q == REFILL) && i_r.last;
    assign o_wr.index   = lkp_index;
    assign o_wr.slot    = beat_q[1 +: SLOT_W];
    assign o_wr.word    = i_r.data;
    assign o_wr_way     = victim_q;
    assign o_wr_tag     = lkp_q.addr[31 -: LEN_TAG];

    assign o_ar     = ar_q;
    assign o_rready = rready_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            lkp_q.valid <= 1'b0;
        end else if (!o_stall) begin
            lkp_q <= i_fetch;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= IDLE;
            done_q     <= 1'b0;
            ar_q.valid <= 1'b0;
            rready_q   <= 1'b0;
            lru_q      <= '0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (miss) begin
                        ar_q.valid <= 1'b1;
                        ar_q.size  <= 3'd2;
                        if (lkp_q.no_cache) begin
                            ar_q.addr <= {lkp_q.addr[31:2], 2'b00};
                            ar_q.len  <= 8'd0;
                            state_q   <= UNCACHED;
                        end else begin
                            ar_q.addr <= {lkp_q.addr[31:LEN_LINE], {LEN_LINE{1'b0}}};
                            ar_q.len  <= 8'(NR_WORDS - 1);
                            state_q   <= REFILL;
                            // victim becomes most recently used
                            lru_q[lkp_index] <= ~lru_q[lkp_index];
                        end
                    end else if (lookup_live) begin
                        lru_q[lkp_index] <= ~i_way1.hit;
                    end
                end
                REFILL, UNCACHED: begin
                    if (ar_q.valid && i_arready) begin
                        ar_q.valid <= 1'b0;
                        rready_q   <= 1'b1;
                    end
                    if (beat && i_r.last) begin
                        rready_q <= 1'b0;
                        done_q   <= 1'b1;
                        state_q  <= IDLE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (miss) begin
            victim_q <= lru_q[lkp_index];
            beat_q   <= '0;
        end
        if (beat) begin
            beat_q <= beat_q + 1'b1;
            if (state_q == UNCACHED) begin
                cap_lo_q <= i_r.data;
                cap_hi_q <= lkp_q.addr[2] ? i_r.data : 32'h0;
            end else if (beat_q[1 +: SLOT_W] == lkp_slot) begin
                if (beat_q[0]) begin
                    cap_hi_q <= i_r.data;
                end else begin
                    cap_lo_q <= i_r.data;
                end
            end
        end
    end

endmodule

// ==== hdl/icache_way.sv ====
`timescale 1ns/1ps

module icache_way (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             i_lookup_en,
    input  logic [icache_pkg::LEN_INDEX-1:0] i_index,
    input  logic [icache_pkg::SLOT_W-1:0]    i_slot,
    input  icache_pkg::tag_t                 i_tag,
    input  icache_pkg::refill_wr_t           i_wr,
    input  logic                             i_wr_sel,
    input  icache_pkg::tag_t                 i_wr_tag,
    output icache_pkg::way_result_t          o_result
);
    import icache_pkg::*;

    logic [(1 << LEN_INDEX)-1:0] valid_q;
    logic                        valid_rd_q;
    tag_t                        tag_q;
    tag_t                        tag_rd;
    logic [1:0][31:0]            data_rd;
    logic                        tag_we;
    logic [SLOT_ADDR_W-1:0]      rd_addr;
    logic [SLOT_ADDR_W-1:0]      wr_addr;

    assign tag_we  = i_wr_sel && i_wr.tag_we;
    assign rd_addr = {i_index, i_slot};
    assign wr_addr = {i_wr.index, i_wr.slot};

    icache_ram #(
        .T      (tag_t),
        .ADDR_W (LEN_INDEX)
    ) tag_ram_inst (
        .clk     (clk),
        .i_we    (tag_we),
        .i_waddr (i_wr.index),
        .i_wdata (i_wr_tag),
        .i_re    (i_lookup_en),
        .i_raddr (i_index),
        .o_rdata (tag_rd)
    );

    // half 0 holds the slot base word and half 1 the word at base + 4
    for (genvar h = 0; h < 2; h++) begin : g_half
        icache_ram #(
            .T      (logic [31:0]),
            .ADDR_W (SLOT_ADDR_W)
        ) data_ram_inst (
            .clk     (clk),
            .i_we    (i_wr_sel && i_wr.data_we && (i_wr.half == 1'(h))),
            .i_waddr (wr_addr),
            .i_wdata (i_wr.word),
            .i_re    (i_lookup_en),
            .i_raddr (rd_addr),
            .o_rdata (data_rd[h])
        );
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (tag_we) begin
            valid_q[i_wr.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_rd_q <= 1'b0;
        end else if (i_lookup_en) begin
            valid_rd_q <= valid_q[i_index];
        end
    end

    always_ff @(posedge clk) begin
        if (i_lookup_en) begin
            tag_q <= i_tag;
        end
    end

    assign o_result.hit  = valid_rd_q && (tag_rd == tag_q);
    assign o_result.pair = data_rd;

endmodule

// ==== hdl/icache_ram.sv ====
`timescale 1ns/1ps

module icache_ram #(
    parameter type T      = logic [31:0],
    parameter int  ADDR_W = 7
) (
    input  logic              clk,
    input  logic              i_we,
    input  logic [ADDR_W-1:0] i_waddr,
    input  T                  i_wdata,
    input  logic              i_re,
    input  logic [ADDR_W-1:0] i_raddr,
    output T                  o_rdata
);

    T mem [1 << ADDR_W];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // output holds while no read is requested
    always_ff @(posedge clk) begin
        if (i_re) begin
            o_rdata <= mem[i_raddr];
        end
    end

endmodule

// ==== hdl/icache_pkg.sv ====
package icache_pkg;

    // cache geometry
    localparam int LEN_LINE    = 6;
    localparam int LEN_INDEX   = 7;
    localparam int LEN_TAG     = 19;
    localparam int NR_WORDS    = 16;
    localparam int NR_SLOTS    = 8;
    localparam int SLOT_ADDR_W = 10;
    localparam int SLOT_W      = $clog2(NR_SLOTS);

    typedef logic [LEN_TAG-1:0] tag_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic        no_cache;
    } fetch_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] inst1;
        logic [31:0] inst2;
    } fetch_resp_t;

    // one way's lookup answer
    typedef struct packed {
        logic        hit;
        logic [63:0] pair;
    } way_result_t;

    typedef struct packed {
        logic                 data_we;
        logic                 half;
        logic                 tag_we;
        logic [LEN_INDEX-1:0] index;
        logic [SLOT_W-1:0]    slot;
        logic [31:0]          word;
    } refill_wr_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [7:0]  len;
        logic [2:0]  size;
    } axi_ar_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] data;
        logic        last;
    } axi_r_t;

endpackage
